// File: common/core_defines.svh
/* Opcode, ALU and selector encodings of the core.
   Only DMEM_WORDS may change; it must stay a power of two */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define REG_COUNT   8
`define DMEM_WORDS  256

// Major opcodes, instr[15:11]
`define OP_HALT   5'b00000
`define OP_NOP    5'b00001
`define OP_J      5'b00100
`define OP_JR     5'b00101
`define OP_JAL    5'b00110
`define OP_JALR   5'b00111
`define OP_ADDI   5'b01000
`define OP_SUBI   5'b01001
`define OP_XORI   5'b01010
`define OP_ANDNI  5'b01011
`define OP_BEQZ   5'b01100
`define OP_BNEZ   5'b01101
`define OP_BLTZ   5'b01110
`define OP_BGEZ   5'b01111
`define OP_ST     5'b10000
`define OP_LD     5'b10001
`define OP_SLBI   5'b10010
`define OP_ROLI   5'b10100
`define OP_SLLI   5'b10101
`define OP_RORI   5'b10110
`define OP_SRLI   5'b10111
`define OP_LBI    5'b11000
`define OP_SHFR   5'b11010   // ROL, SLL, ROR, SRL by funct
`define OP_ALUR   5'b11011   // ADD, SUB, XOR, ANDN by funct
`define OP_SEQ    5'b11100
`define OP_SLT    5'b11101
`define OP_SLE    5'b11110
`define OP_SCO    5'b11111

// ALU codes, grouped so the low two bits match opcode or funct
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_XOR   4'd2
`define ALU_ANDN  4'd3
`define ALU_ROL   4'd4
`define ALU_SLL   4'd5
`define ALU_ROR   4'd6
`define ALU_SRL   4'd7
`define ALU_SEQ   4'd8
`define ALU_SLT   4'd9
`define ALU_SLE   4'd10
`define ALU_SCO   4'd11
`define ALU_LBI   4'd12
`define ALU_SLBI  4'd13

// Next-PC, write index, write data and operand B selectors
`define PC_SEQ    2'd0
`define PC_BR     2'd1
`define PC_JMP    2'd2
`define PC_JREG   2'd3
`define DST_IRD   2'd0
`define DST_RRD   2'd1
`define DST_RS    2'd2
`define DST_R7    2'd3
`define SRC_PC2   2'd0
`define SRC_MEM   2'd1
`define SRC_ALU   2'd2
`define B_REG     2'd0
`define B_IMM5    2'd1
`define B_IMM8    2'd2

`endif

// File: common/wiscPkg.sv
/* Types shared by the core blocks.
   Field encodings come from core_defines.svh */
package wiscPkg;

    typedef logic [15:0] word_t;    // Data or byte address
    typedef logic [2:0]  regIdx_t;
    typedef logic [3:0]  aluOp_t;
    typedef logic [1:0]  pcSel_t;

    // Decoder output, one instruction per cycle
    typedef struct packed {
        logic        regWrt;
        logic [1:0]  regDst;       // I rd, R rd, rs or r7
        logic [1:0]  regSrc;       // PC+2, memory or ALU
        logic [1:0]  bSrc;         // Register, imm5 or imm8
        logic        zeroExt;
        logic        memWrt;
        logic        memRead;
        aluOp_t      aluOp;
        pcSel_t      pcSel;
        logic [1:0]  branchCond;   // EQZ, NEZ, LTZ, GEZ
        logic        halt;
        logic        err;
    } ctrl_t;

    // Register write seen at retirement
    typedef struct packed {
        logic    en;
        regIdx_t idx;
        word_t   data;
    } wb_t;

endpackage

// File: hw/control.sv
/* Combinational decoder of the major opcode and R-form funct bits.
   STU, BTR, SIIC and RTI fall to the illegal path */
`timescale 1ns/1ps
`include "core_defines.svh"

module control (
    input  wiscPkg::word_t instr,
    output wiscPkg::ctrl_t ctrl
);

    always_comb begin
        ctrl = '0;
        ctrl.regDst = `DST_IRD;
        ctrl.regSrc = `SRC_ALU;
        ctrl.bSrc = `B_REG;
        ctrl.aluOp = `ALU_ADD;
        ctrl.pcSel = `PC_SEQ;

        case (instr[15:11])
            `OP_HALT: ctrl.halt = 1'b1;
            `OP_NOP: ;
            `OP_ADDI, `OP_SUBI, `OP_XORI, `OP_ANDNI: begin
                ctrl.regWrt = 1'b1;
                ctrl.bSrc = `B_IMM5;
                ctrl.zeroExt = instr[12];                  // XORI and ANDNI
                ctrl.aluOp = {2'b00, instr[12:11]};
            end
            `OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI: begin
                ctrl.regWrt = 1'b1;
                ctrl.bSrc = `B_IMM5;
                ctrl.zeroExt = 1'b1;
                ctrl.aluOp = {2'b01, instr[12:11]};
            end
            `OP_ST: begin
                ctrl.memWrt = 1'b1;                        // Address is rs + imm5
                ctrl.bSrc = `B_IMM5;
            end
            `OP_LD: begin
                ctrl.regWrt = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.regSrc = `SRC_MEM;
                ctrl.bSrc = `B_IMM5;
            end
            `OP_LBI, `OP_SLBI: begin
                ctrl.regWrt = 1'b1;
                ctrl.regDst = `DST_RS;
                ctrl.bSrc = `B_IMM8;
                ctrl.zeroExt = ~instr[14];                 // SLBI takes a raw byte
                ctrl.aluOp = instr[14] ? `ALU_LBI : `ALU_SLBI;
            end
            `OP_ALUR, `OP_SHFR: begin
                ctrl.regWrt = 1'b1;
                ctrl.regDst = `DST_RRD;
                ctrl.aluOp = {1'b0, ~instr[11], instr[1:0]};
            end
            `OP_SEQ, `OP_SLT, `OP_SLE, `OP_SCO: begin
                ctrl.regWrt = 1'b1;
                ctrl.regDst = `DST_RRD;
                ctrl.aluOp = {2'b10, instr[12:11]};
            end
            `OP_BEQZ, `OP_BNEZ, `OP_BLTZ, `OP_BGEZ: begin
                ctrl.pcSel = `PC_BR;
                ctrl.branchCond = instr[12:11];
            end
            `OP_J: ctrl.pcSel = `PC_JMP;
            `OP_JR: ctrl.pcSel = `PC_JREG;
            `OP_JAL, `OP_JALR: begin
                ctrl.pcSel = instr[11] ? `PC_JREG : `PC_JMP;
                ctrl.regWrt = 1'b1;
                ctrl.regDst = `DST_R7;                     // Link register
                ctrl.regSrc = `SRC_PC2;
            end
            default: begin
                ctrl.err = 1'b1;
                ctrl.halt = 1'b1;
            end
        endcase
    end

endmodule

// File: hw/regFile.sv
/* Register file with two asynchronous reads and one write per edge.
   A read in the same cycle as a write sees the old value */
`timescale 1ns/1ps
`include "core_defines.svh"

module regFile (
    input  logic             clk,
    input  logic             arstN,
    input  wiscPkg::regIdx_t rsIdx,
    input  wiscPkg::regIdx_t rtIdx,
    input  wiscPkg::regIdx_t wrIdx,
    input  logic             wrEn,
    input  wiscPkg::word_t   wrData,
    output wiscPkg::word_t   rsData,
    output wiscPkg::word_t   rtData
);
    import wiscPkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

    assign rsData = regs[rsIdx];
    assign rtData = regs[rtIdx];

endmodule

// File: hw/alu.sv
/* Single-cycle ALU. Shifts use b[3:0]; SUB gives b - a.
   zero and neg describe operand a, which is rs for branches */
`timescale 1ns/1ps
`include "core_defines.svh"

module alu (
    input  wiscPkg::aluOp_t aluOp,
    input  wiscPkg::word_t  a,
    input  wiscPkg::word_t  b,
    output wiscPkg::word_t  result,
    output logic            zero,
    output logic            neg
);

    logic [3:0]  shamt;
    logic [16:0] sum;
    logic [31:0] rotL;
    logic [31:0] rotR;

    assign shamt = b[3:0];
    assign sum = {1'b0, a} + {1'b0, b};          // Carry kept for SCO
    assign rotL = {a, a} << shamt;
    assign rotR = {a, a} >> shamt;

    always_comb begin
        case (aluOp)
            `ALU_ADD:  result = sum[15:0];
            `ALU_SUB:  result = b - a;
            `ALU_XOR:  result = a ^ b;
            `ALU_ANDN: result = a & ~b;
            `ALU_ROL:  result = rotL[31:16];
            `ALU_SLL:  result = a << shamt;
            `ALU_ROR:  result = rotR[15:0];
            `ALU_SRL:  result = a >> shamt;
            `ALU_SEQ:  result = {15'b0, a == b};
            `ALU_SLT:  result = {15'b0, $signed(a) < $signed(b)};
            `ALU_SLE:  result = {15'b0, $signed(a) <= $signed(b)};
            `ALU_SCO:  result = {15'b0, sum[16]};
            `ALU_LBI:  result = b;                       // Already sign-extended
            `ALU_SLBI: result = {a[7:0], b[7:0]};
            default:   result = '0;
        endcase
    end

    assign zero = (a == '0);
    assign neg = a[15];

endmodule

// File: hw/pcLogic.sv
/* PC register and next-PC choice. A halt request freezes the PC on the
   halting instruction, so the fetch address stays there until reset */
`timescale 1ns/1ps
`include "core_defines.svh"

module pcLogic (
    input  logic            clk,
    input  logic            arstN,
    input  wiscPkg::pcSel_t pcSel,
    input  logic [1:0]      branchCond,
    input  logic            zero,
    input  logic            neg,
    input  logic [10:0]     disp,
    input  logic [7:0]      imm,
    input  wiscPkg::word_t  rsData,
    input  logic            haltReq,
    output wiscPkg::word_t  pc,
    output wiscPkg::word_t  pcPlus2,
    output logic            halted
);
    import wiscPkg::*;

    word_t immExt;
    word_t dispExt;
    word_t nextPc;
    logic  taken;

    assign pcPlus2 = pc + 16'd2;
    assign immExt = {{8{imm[7]}}, imm};
    assign dispExt = {{5{disp[10]}}, disp};

    always_comb begin
        case (branchCond)
            2'b00:   taken = zero;
            2'b01:   taken = ~zero;
            2'b10:   taken = neg;
            default: taken = ~neg;
        endcase
        case (pcSel)
            `PC_BR:   nextPc = taken ? pcPlus2 + immExt : pcPlus2;
            `PC_JMP:  nextPc = pcPlus2 + dispExt;
            `PC_JREG: nextPc = rsData + immExt;
            default:  nextPc = pcPlus2;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            halted <= haltReq;
            if (!haltReq) pc <= nextPc;
        end
    end

endmodule

// File: hw/dataMem.sv
/* Word data memory of DMEM_WORDS entries, indexed by addr above bit 0.
   Upper address bits beyond the depth are ignored, so addresses wrap */
`timescale 1ns/1ps
`include "core_defines.svh"

module dataMem (
    input  logic           clk,
    input  logic           arstN,
    input  wiscPkg::word_t addr,
    input  logic           wrEn,
    input  wiscPkg::word_t wrData,
    output wiscPkg::word_t rdData
);
    import wiscPkg::*;

    localparam int AW = $clog2(`DMEM_WORDS);

    word_t mem [`DMEM_WORDS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `DMEM_WORDS; i++) mem[i] <= '0;
        end else if (wrEn) begin
            mem[addr[AW:1]] <= wrData;
        end
    end

    assign rdData = mem[addr[AW:1]];             // Byte address, word aligned

endmodule

// File: hw/wiscCore.sv
/* Single-cycle core top. instr must be valid in the cycle fetchAddr is shown
   and must not change while the address holds; errFlag relies on that */
`timescale 1ns/1ps
`include "core_defines.svh"

module wiscCore (
    input  logic           clk,
    input  logic           arstN,
    input  wiscPkg::word_t instr,
    output wiscPkg::word_t fetchAddr,
    output wiscPkg::wb_t   retire,
    output logic           halted,
    output logic           errFlag
);
    import wiscPkg::*;

    ctrl_t   ctrl;
    word_t   rsData, rtData, aluB, aluResult;
    word_t   memRdData, pc, pcPlus2, wbData, imm5Ext, imm8Ext;
    regIdx_t wrIdx;
    logic    zero, neg, regWrEn, memWrEn;

    control control_i (.instr(instr), .ctrl(ctrl));

    assign imm5Ext = ctrl.zeroExt ? {11'b0, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
    assign imm8Ext = ctrl.zeroExt ? {8'b0, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};
    assign aluB = (ctrl.bSrc == `B_IMM5) ? imm5Ext :
                  (ctrl.bSrc == `B_IMM8) ? imm8Ext : rtData;

    assign wrIdx = (ctrl.regDst == `DST_RRD) ? instr[4:2] :
                   (ctrl.regDst == `DST_RS)  ? instr[10:8] :
                   (ctrl.regDst == `DST_R7)  ? 3'd7 : instr[7:5];
    assign wbData = (ctrl.regSrc == `SRC_PC2) ? pcPlus2 :
                    (ctrl.regSrc == `SRC_MEM && ctrl.memRead) ? memRdData : aluResult;

    assign regWrEn = ctrl.regWrt & ~halted;      // Nothing retires once halted
    assign memWrEn = ctrl.memWrt & ~halted;

    regFile regFile_i (
        .clk(clk), .arstN(arstN), .rsIdx(instr[10:8]), .rtIdx(instr[7:5]),
        .wrIdx(wrIdx), .wrEn(regWrEn), .wrData(wbData), .rsData(rsData), .rtData(rtData)
    );

    alu alu_i (
        .aluOp(ctrl.aluOp), .a(rsData), .b(aluB), .result(aluResult),
        .zero(zero), .neg(neg)
    );

    pcLogic pcLogic_i (
        .clk(clk), .arstN(arstN), .pcSel(ctrl.pcSel), .branchCond(ctrl.branchCond),
        .zero(zero), .neg(neg), .disp(instr[10:0]), .imm(instr[7:0]), .rsData(rsData),
        .haltReq(ctrl.halt), .pc(pc), .pcPlus2(pcPlus2), .halted(halted)
    );

    // Store data is the rd field, which is the rt read port
    dataMem dataMem_i (
        .clk(clk), .arstN(arstN), .addr(aluResult), .wrEn(memWrEn),
        .wrData(rtData), .rdData(memRdData)
    );

    assign fetchAddr = pc;
    assign retire = '{en: regWrEn, idx: wrIdx, data: wbData};
    assign errFlag = halted & ctrl.err;          // PC stays on the illegal word

endmodule

// File: bench/wiscCore_checker.sv
/* Concurrent checks bound into every wiscCore instance */
`timescale 1ns/1ps

module wiscCore_checker (
    input logic           clk,
    input logic           arstN,
    input wiscPkg::ctrl_t ctrl,
    input wiscPkg::word_t pc,
    input wiscPkg::word_t fetchAddr,
    input wiscPkg::wb_t   retire,
    input logic           halted
);

    // A store never writes a register
    stNoRegWrite: assert property (@(posedge clk) disable iff (!arstN)
        ctrl.memWrt |-> !ctrl.regWrt) else $error("ST with register write");

    pcHoldsHalted: assert property (@(posedge clk) disable iff (!arstN)
        halted |=> $stable(pc)) else $error("PC moved while halted");

    noRetireHalted: assert property (@(posedge clk) disable iff (!arstN)
        halted |-> !retire.en) else $error("Retirement while halted");

    fetchEven: assert property (@(posedge clk) disable iff (!arstN)
        !fetchAddr[0]) else $error("Odd fetch address");

endmodule

bind wiscCore wiscCore_checker checker_i (
    .clk(clk), .arstN(arstN), .ctrl(ctrl), .pc(pc), .fetchAddr(fetchAddr),
    .retire(retire), .halted(halted)
);

// File: bench/wiscCoreTb.sv
/* Testbench for wiscCore. Programs and the expected retirement trace come from
   bench/program_cases.txt; run from the project root. Each instruction runs once */
`timescale 1ns/1ps

module wiscCoreTb;
    import wiscPkg::*;

    localparam int MAX_CASES = 64;
    localparam int NUM_PROGS = 2;

    logic  clk;
    logic  arstN;
    word_t instr;
    word_t fetchAddr;
    wb_t   retire;
    logic  halted;
    logic  errFlag;

    word_t imem [256];                           // Indexed by fetch address bits 8:1
    int    caseProg [MAX_CASES];
    word_t caseAddr [MAX_CASES];
    word_t caseInstr [MAX_CASES];
    wb_t   caseWb [MAX_CASES];
    word_t caseNext [MAX_CASES];
    int    haltErr [NUM_PROGS];
    int    nCases;
    int    errors;
    logic  loaded;

    wiscCore dut_i (
        .clk(clk), .arstN(arstN), .instr(instr), .fetchAddr(fetchAddr),
        .retire(retire), .halted(halted), .errFlag(errFlag)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // C lines give one executed instruction, H lines the final error flag
    function automatic int readCases();
        int    fd;
        string line;
        int    p, a, i, e, x, d, nx;
        fd = $fopen("bench/program_cases.txt", "r");
        if (fd == 0) return 0;
        nCases = 0;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) continue;
            if ($sscanf(line, "C %h %h %h %h %h %h %h", p, a, i, e, x, d, nx) == 7) begin
                caseProg[nCases] = p;
                caseAddr[nCases] = a[15:0];
                caseInstr[nCases] = i[15:0];
                caseWb[nCases] = '{en: e[0], idx: x[2:0], data: d[15:0]};
                caseNext[nCases] = nx[15:0];
                nCases++;
            end else if ($sscanf(line, "H %h %h", p, e) == 2) begin
                haltErr[p] = e;
            end
        end
        $fclose(fd);
        return nCases;
    endfunction

    task automatic loadProgram(input int p);
        for (int w = 0; w < 256; w++) begin
            imem[w] = {5'b00001, 3'b000, w[7:0]};    // NOP tagged with its own index
        end
        for (int k = 0; k < nCases; k++) begin
            if (caseProg[k] == p) imem[caseAddr[k][8:1]] = caseInstr[k];
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        arstN <= 1'b0;
        instr <= imem[0];
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
    endtask

    task automatic runProgram(input int p);
        word_t expPc;
        expPc = '0;
        for (int k = 0; k < nCases; k++) begin
            if (caseProg[k] != p) continue;
            @(negedge clk);
            if (fetchAddr !== expPc) begin
                $display("** Error at %0t: fetchAddr %h, expected %h", $time, fetchAddr, expPc);
                errors++;
            end
            if (halted !== 1'b0 || errFlag !== 1'b0) begin
                $display("** Error at %0t: pc %h halted %b errFlag %b before its stop",
                         $time, expPc, halted, errFlag);
                errors++;
            end
            if (retire.en !== caseWb[k].en || (caseWb[k].en &&
                (retire.idx !== caseWb[k].idx || retire.data !== caseWb[k].data))) begin
                $display("** Error at %0t: pc %h retire en %b r%0d=%h, expected en %b r%0d=%h",
                         $time, expPc, retire.en, retire.idx, retire.data,
                         caseWb[k].en, caseWb[k].idx, caseWb[k].data);
                errors++;
            end
            @(posedge clk);
            instr <= imem[caseNext[k][8:1]];     // Next fetch follows the expected PC
            expPc = caseNext[k];
        end
        repeat (3) begin
            @(negedge clk);
            if (halted !== 1'b1 || retire.en !== 1'b0 || fetchAddr !== expPc ||
                errFlag !== haltErr[p][0]) begin
                $display("** Error at %0t: halted %b en %b fetchAddr %h errFlag %b after stop",
                         $time, halted, retire.en, fetchAddr, errFlag);
                errors++;
            end
        end
    endtask

    initial begin
        arstN = 1'b0;
        instr = '0;
        errors = 0;
        loaded = 1'b0;
        if (readCases() == 0) begin
            $display("Could not read any case from bench/program_cases.txt");
            $display("Checks failed");
            $finish;
        end else begin
            loaded = 1'b1;
            for (int p = 0; p < NUM_PROGS; p++) begin
                loadProgram(p);
                applyReset();
                runProgram(p);
            end
            $display("Errors: %0d", errors);
            if (errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // Each case takes one cycle, plus reset and stop checks per program
    initial begin
        wait (loaded);
        #((nCases + 20 + NUM_PROGS * 12) * 4);
        $display("Watchdog expired at %0t before the tests completed", $time);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: bench/program_cases.txt
# C prog addr instr retireEn retireIdx retireData nextFetch (hex, execution order)
# H prog errFlag expected once halted
C 0 0000 C112 1 1 0012 0002
C 0 0002 9134 1 1 1234 0004
C 0 0004 C2F0 1 2 FFF0 0006
C 0 0006 417F 1 3 1233 0008
C 0 0008 4985 1 4 EDD1 000A
C 0 000A 51BF 1 5 122B 000C
C 0 000C 5AB0 1 5 FFE0 000E
C 0 000E A1C4 1 6 2341 0010
C 0 0010 BAC4 1 6 0FFF 0012
C 0 0012 D978 1 6 2467 0014
C 0 0014 D97D 1 7 FFFF 0016
C 0 0016 D19E 1 7 091A 0018
C 0 0018 EA3C 1 7 0001 001A
C 0 001A F97C 1 7 0000 001C
C 0 001C 8024 0 0 0000 001E
C 0 001E 88A4 1 5 1234 0020
C 0 0020 6002 0 0 0000 0024
C 0 0024 6102 0 0 0000 0026
C 0 0026 6902 0 0 0000 002A
C 0 002A 6802 0 0 0000 002C
C 0 002C 7202 0 0 0000 0030
C 0 0030 7102 0 0 0000 0032
C 0 0032 7902 0 0 0000 0036
C 0 0036 7A02 0 0 0000 0038
C 0 0038 2004 0 0 0000 003E
C 0 003E 3002 1 7 0040 0042
C 0 0042 C450 1 4 0050 0044
C 0 0044 2C02 0 0 0000 0052
C 0 0052 3C08 1 7 0054 0058
C 0 0058 0000 0 0 0000 0058
H 0 0
C 1 0000 C105 1 1 0005 0002
C 1 0002 9800 0 0 0000 0002
H 1 1

// File: sim.f
+incdir+common
common/wiscPkg.sv
hw/control.sv
hw/regFile.sv
hw/alu.sv
hw/pcLogic.sv
hw/dataMem.sv
hw/wiscCore.sv
bench/wiscCore_checker.sv
bench/wiscCoreTb.sv

// File: Makefile
# Verilator build and run for the wiscCore testbench
VERILATOR ?= verilator
TOP       ?= wiscCoreTb
BUILD     ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= All checks passed

SIM := $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qx "$(PASS_TEXT)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD)
